/* common/ide_params.svh */
`ifndef IDE_PARAMS_SVH
`define IDE_PARAMS_SVH

// Host data port width in bits.
`define IDE_DATA_W 32

// Address width of one buffer half (4096 words of 16 bits).
`define IDE_BUF_AW 12

// Width of the host and management word counters.
`define IDE_CNT_W 14

// Number of registers on each bus.
`define IDE_NREGS 16

`endif

/* common/ide_regs_pkg.sv */
`default_nettype none
`include "ide_params.svh"

package ide_regs_pkg;

	typedef logic [7:0]  tf_byte_t;   // One task-file register byte.
	typedef logic [15:0] tf_word_t;   // Management data word.
	typedef logic [31:0] lba_hi_t;    // Cylinder low and high with their HOB bytes.
	typedef logic [$clog2(`IDE_NREGS)-1:0] io_addr_t;
	typedef logic [$clog2(`IDE_NREGS)-1:0] mgmt_addr_t;

	// Host register map. Address 14 is alternate status on read and device control on write.
	localparam io_addr_t IO_DATA    = 4'd0;
	localparam io_addr_t IO_FEATURE = 4'd1;
	localparam io_addr_t IO_SECCNT  = 4'd2;
	localparam io_addr_t IO_SECTOR  = 4'd3;
	localparam io_addr_t IO_CYL_LO  = 4'd4;
	localparam io_addr_t IO_CYL_HI  = 4'd5;
	localparam io_addr_t IO_DRVHEAD = 4'd6;
	localparam io_addr_t IO_CMD     = 4'd7;
	localparam io_addr_t IO_DEVCTL  = 4'd14;
	localparam io_addr_t IO_DRVADDR = 4'd15;

	// Management register map.
	localparam mgmt_addr_t MG_PARAM  = 4'd0;
	localparam mgmt_addr_t MG_TF_LO  = 4'd1;
	localparam mgmt_addr_t MG_CYL_LO = 4'd2;
	localparam mgmt_addr_t MG_TF_HI  = 4'd3;
	localparam mgmt_addr_t MG_CYL_HI = 4'd4;
	localparam mgmt_addr_t MG_STATUS = 4'd5;
	localparam mgmt_addr_t MG_CONFIG = 4'd6;
	localparam mgmt_addr_t MG_DATA   = 4'd15;

endpackage

`default_nettype wire

/* common/ide_xfer_pkg.sv */
`default_nettype none
`include "ide_params.svh"

package ide_xfer_pkg;

	// ##########################################################################
	// Request codes to the management side.
	// ##########################################################################

	typedef logic [2:0] req_code_t;

	localparam req_code_t REQ_IDLE  = 3'b000;
	localparam req_code_t REQ_CMD   = 3'b100;   // New command written by the host.
	localparam req_code_t REQ_DATA  = 3'b101;   // Next data block is wanted.
	localparam req_code_t REQ_RESET = 3'b110;

	// ##########################################################################
	// Status byte and transfer state.
	// ##########################################################################

	typedef logic [7:0] status_t;

	localparam int ST_BSY = 7;
	localparam int ST_DRQ = 3;

	localparam status_t STAT_BUSY  = 8'h80;   // After reset and while a command is queued.
	localparam status_t STAT_READY = 8'h40;

	typedef logic [`IDE_CNT_W-1:0] xfer_cnt_t;

	typedef enum logic [1:0] {
		PH_RESET,   // Hardware or software reset seen.
		PH_BUSY,    // Waiting on the management side.
		PH_DATA,    // Block transfer with drq held.
		PH_DONE
	} cmd_phase_e;

endpackage

`default_nettype wire

/* hw/dpram.sv */
`timescale 1ns/1ps
`default_nettype none

module dpram #(
	parameter int ADDR_W = 12,
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  logic [ADDR_W-1:0] address_a,
	input  logic [DATA_W-1:0] data_a,
	input  logic              wren_a,
	output logic [DATA_W-1:0] q_a,
	input  logic [ADDR_W-1:0] address_b,
	input  logic [DATA_W-1:0] data_b,
	input  logic              wren_b,
	output logic [DATA_W-1:0] q_b
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// Both ports read the old word during a write.
	always @(posedge clk) begin
		if (wren_a)
			mem[address_a] <= data_a;
		q_a <= mem[address_a];
	end

	always @(posedge clk) begin
		if (wren_b)
			mem[address_b] <= data_b;
		q_b <= mem[address_b];
	end

endmodule

`default_nettype wire

/* ide/ide_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ide_params.svh"

module ide_sequencer
	import ide_regs_pkg::*, ide_xfer_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  io_addr_t              io_address,
	input  logic                  io_read,
	input  logic                  io_write,
	input  tf_byte_t              io_writedata,
	input  mgmt_addr_t            mgmt_address,
	input  logic                  mgmt_write,
	input  tf_word_t              mgmt_writedata,
	input  logic                  drv_sel,
	input  logic                  io_done,
	output logic [`IDE_NREGS-1:0] io_reg_we,
	output logic [`IDE_NREGS-1:0] mgmt_reg_we,
	output logic                  reset,
	output status_t               status,
	output req_code_t             request,
	output logic                  irq,
	output logic                  io_wait,
	output logic                  hob,
	output logic [1:0]            present,
	output logic                  fast_read
);

	cmd_phase_e phase;
	status_t    post_status;
	logic [1:0] hob_ena;
	logic       use_wait;
	logic       sw_reset;
	logic       disable_irq;
	logic       hob_pre;
	logic       last_read;
	logic       post;
	logic       blk_end;

	// ##########################################################################
	// Bus decode and configuration.
	// ##########################################################################

	// Host writes are dropped while neither drive is present.
	assign io_reg_we   = (io_write && |present) ? `IDE_NREGS'(1) << io_address : '0;
	assign mgmt_reg_we = mgmt_write ? `IDE_NREGS'(1) << mgmt_address : '0;

	assign post    = mgmt_reg_we[MG_STATUS];
	assign blk_end = io_done && phase == PH_DATA;
	assign reset   = !rst_n || sw_reset;

	// Status as posted by the management side, bit 5 and bits 2:1 read as zero.
	assign post_status = {mgmt_writedata[15:14], 1'b0, mgmt_writedata[12:11], 2'b00,
		mgmt_writedata[8]};

	// Each drive field has its own enable bit in the same word.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			present  <= '0;
			hob_ena  <= '0;
			use_wait <= 1'b0;
		end else if (mgmt_reg_we[MG_CONFIG]) begin
			if (mgmt_writedata[3])
				{hob_ena[0], present[0]} <= mgmt_writedata[1:0];
			if (mgmt_writedata[7])
				{hob_ena[1], present[1]} <= mgmt_writedata[5:4];
			if (mgmt_writedata[9])
				use_wait <= mgmt_writedata[8];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			sw_reset <= 1'b0;
		else if (io_reg_we[IO_DEVCTL])
			sw_reset <= io_writedata[2];   // SRST holds the device in reset.
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			disable_irq <= 1'b0;
			hob_pre     <= 1'b0;
			hob         <= 1'b0;
		end else begin
			if (io_reg_we[IO_DEVCTL]) begin
				disable_irq <= io_writedata[1];
				hob_pre     <= io_writedata[7];
			end
			hob <= hob_pre && hob_ena[drv_sel];   // Only for a drive with 48-bit support.
		end
	end

	// ##########################################################################
	// Command phases.
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			phase     <= PH_RESET;
			status    <= STAT_BUSY;
			request   <= REQ_RESET;
			last_read <= 1'b0;
			fast_read <= 1'b0;
		end else if (post) begin
			status    <= post_status;
			request   <= REQ_IDLE;
			last_read <= mgmt_writedata[9];
			fast_read <= mgmt_writedata[13];
			if (post_status[ST_DRQ])
				phase <= PH_DATA;
			else if (post_status[ST_BSY])
				phase <= PH_BUSY;
			else
				phase <= PH_DONE;
		end else if (io_reg_we[IO_CMD]) begin
			phase   <= PH_BUSY;
			status  <= STAT_BUSY;
			request <= REQ_CMD;
		end else if (blk_end) begin
			last_read <= 1'b0;
			fast_read <= 1'b0;
			if (last_read) begin
				phase  <= PH_DONE;
				status <= STAT_READY;
			end else begin
				phase   <= PH_BUSY;
				status  <= STAT_BUSY;
				request <= REQ_DATA;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			irq <= 1'b0;
		else if (post && mgmt_writedata[10] && !disable_irq)
			irq <= 1'b1;
		else if (io_reg_we[IO_CMD] || (io_read && io_address == IO_CMD))
			irq <= 1'b0;   // Reading status acknowledges the interrupt.
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			io_wait <= 1'b0;
		else if (sw_reset)
			io_wait <= use_wait;
		else if (post)
			io_wait <= 1'b0;
		else if (io_reg_we[IO_CMD] || (blk_end && !last_read))
			io_wait <= use_wait;
	end

	// A data request only follows a block that ran with drq high.
	assert property (@(posedge clk) disable iff (reset)
		$rose(request == REQ_DATA) |-> $past(status[ST_DRQ]));

endmodule

`default_nettype wire

/* ide/ide_taskfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ide_params.svh"

module ide_taskfile
	import ide_regs_pkg::*, ide_xfer_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   reset,
	input  logic [`IDE_NREGS-1:0]  io_reg_we,
	input  logic [`IDE_NREGS-1:0]  mgmt_reg_we,
	input  tf_byte_t               io_writedata,
	input  tf_word_t               mgmt_writedata,
	input  logic                   io_read,
	input  io_addr_t               io_address,
	input  logic                   io_32,
	input  mgmt_addr_t             mgmt_address,
	input  status_t                status,
	input  logic                   hob,
	input  logic [1:0]             present,
	input  logic                   use_fast,
	input  logic                   io_done,
	input  logic [`IDE_DATA_W-1:0] buf_q,
	input  logic [`IDE_DATA_W-1:0] buf_readdata,
	input  logic                   io_word_odd,
	input  logic                   mgmt_word_odd,
	output logic [`IDE_DATA_W-1:0] io_readdata,
	output tf_word_t               mgmt_readdata,
	output logic                   drv_sel,
	output xfer_cnt_t              blk_size
);

	tf_byte_t features;
	tf_byte_t error;
	tf_word_t sector_count;   // HOB byte in the upper half.
	tf_word_t sector;
	lba_hi_t  cylinder;
	tf_byte_t drv_addr;
	tf_byte_t command;
	tf_word_t io_lo;

	assign drv_sel = drv_addr[4];

	// ##########################################################################
	// Registers.
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			features <= '0;
			error    <= '0;
			blk_size <= '0;
			command  <= '0;
		end else begin
			if (io_reg_we[IO_FEATURE])
				features <= io_writedata;
			if (io_reg_we[IO_CMD])
				command <= io_writedata;
			if (mgmt_reg_we[MG_PARAM]) begin
				error    <= mgmt_writedata[15:8];
				blk_size <= {mgmt_writedata[`IDE_CNT_W-9:0], 8'h00};   // In sectors.
			end
		end
	end

	// Software reset reloads the device signature as well.
	always_ff @(posedge clk) begin
		if (reset) begin
			sector_count <= 16'd1;
			sector       <= 16'd1;
			cylinder     <= '1;
			drv_addr     <= '0;
		end else begin
			// A host write moves the previous byte up into the HOB position.
			if (io_reg_we[IO_SECCNT])
				sector_count <= {sector_count[7:0], io_writedata};
			if (io_reg_we[IO_SECTOR])
				sector <= {sector[7:0], io_writedata};
			if (io_reg_we[IO_CYL_LO])
				{cylinder[23:16], cylinder[7:0]} <= {cylinder[7:0], io_writedata};
			if (io_reg_we[IO_CYL_HI])
				{cylinder[31:24], cylinder[15:8]} <= {cylinder[15:8], io_writedata};
			if (io_reg_we[IO_DRVHEAD])
				drv_addr <= io_writedata;

			// Management loads come later and take priority.
			if (mgmt_reg_we[MG_TF_LO]) begin
				sector_count[7:0] <= mgmt_writedata[7:0];
				sector[7:0]       <= mgmt_writedata[15:8];
			end
			if (mgmt_reg_we[MG_TF_HI]) begin
				sector_count[15:8] <= mgmt_writedata[7:0];
				sector[15:8]       <= mgmt_writedata[15:8];
			end
			if (mgmt_reg_we[MG_CYL_LO])
				cylinder[15:0] <= mgmt_writedata;
			if (mgmt_reg_we[MG_CYL_HI])
				cylinder[31:16] <= mgmt_writedata;
			if (mgmt_reg_we[MG_STATUS])
				drv_addr <= mgmt_writedata[7:0];
		end
	end

	// ##########################################################################
	// Read multiplexers.
	// ##########################################################################

	// A 16-bit read of an odd word takes the upper buffer half.
	assign io_lo = (!io_32 && io_word_odd) ? buf_q[31:16] : buf_q[15:0];

	always_ff @(posedge clk) begin
		if (io_read) begin
			if (present == 2'b00) begin
				io_readdata <= '1;   // Floating bus with no drive attached.
			end else begin
				case (io_address)
					IO_DATA:    io_readdata <= status[ST_DRQ] ? {buf_q[31:16], io_lo} : '0;
					IO_FEATURE: io_readdata <= {24'd0, error};
					IO_SECCNT:  io_readdata <= {24'd0, hob ? sector_count[15:8] : sector_count[7:0]};
					IO_SECTOR:  io_readdata <= {24'd0, hob ? sector[15:8] : sector[7:0]};
					IO_CYL_LO:  io_readdata <= {24'd0, hob ? cylinder[23:16] : cylinder[7:0]};
					IO_CYL_HI:  io_readdata <= {24'd0, hob ? cylinder[31:24] : cylinder[15:8]};
					IO_DRVHEAD: io_readdata <= {24'd0, drv_addr};
					IO_CMD,
					IO_DEVCTL:  io_readdata <= {24'd0, status};
					IO_DRVADDR: io_readdata <= {24'd0, 2'b10, ~drv_addr[3:0], ~drv_addr[4], drv_addr[4]};
					default:    io_readdata <= '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		case (mgmt_address)
			MG_PARAM:  mgmt_readdata <= {features, 6'd0, use_fast, io_done};
			MG_TF_LO:  mgmt_readdata <= {sector[7:0], sector_count[7:0]};
			MG_CYL_LO: mgmt_readdata <= cylinder[15:0];
			MG_TF_HI:  mgmt_readdata <= {sector[15:8], sector_count[15:8]};
			MG_CYL_HI: mgmt_readdata <= cylinder[31:16];
			MG_STATUS: mgmt_readdata <= {command, drv_addr};
			MG_DATA:   mgmt_readdata <= mgmt_word_odd ? buf_readdata[31:16] : buf_readdata[15:0];
			default:   mgmt_readdata <= '0;
		endcase
	end

endmodule

`default_nettype wire

/* ide/ide_xfer_buf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ide_params.svh"

module ide_xfer_buf
	import ide_regs_pkg::*, ide_xfer_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   reset,
	input  logic [`IDE_NREGS-1:0]  io_reg_we,
	input  logic [`IDE_NREGS-1:0]  mgmt_reg_we,
	input  logic                   io_read,
	input  io_addr_t               io_address,
	input  logic                   io_32,
	input  logic [`IDE_DATA_W-1:0] io_writedata,
	input  logic                   mgmt_read,
	input  logic                   mgmt_write,
	input  mgmt_addr_t             mgmt_address,
	input  tf_word_t               mgmt_writedata,
	input  status_t                status,
	input  logic                   fast_read,
	input  xfer_cnt_t              blk_size,
	output logic                   io_done,
	output logic                   no_data,
	output logic [`IDE_DATA_W-1:0] buf_q,
	output logic [`IDE_DATA_W-1:0] buf_readdata,
	output logic                   io_word_odd,
	output logic                   mgmt_word_odd
);

	xfer_cnt_t  io_cnt;
	xfer_cnt_t  mgmt_cnt;
	logic       drq;
	logic       wr_data;
	logic       io_stb;
	logic       io_stb_d;
	logic       io_32_d;
	logic       mgmt_wr_d;
	logic       mgmt_rd_d;
	logic       n_data;
	logic [1:0] n_data_d;
	tf_word_t   io_hi_data;

	assign drq     = status[ST_DRQ];
	assign wr_data = io_reg_we[IO_DATA] && drq;
	assign io_stb  = wr_data || (io_read && io_address == IO_DATA && drq);

	// ##########################################################################
	// Word counters.
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (io_stb)
			io_32_d <= io_32;   // Width of the access in progress.
	end

	// The host count moves when the data-port strobe falls.
	always_ff @(posedge clk) begin
		if (reset) begin
			io_stb_d <= 1'b0;
			io_cnt   <= '0;
		end else begin
			io_stb_d <= io_stb;
			if (mgmt_reg_we[MG_STATUS])
				io_cnt <= '0;
			else if (io_stb_d && !io_stb)
				io_cnt <= io_cnt + (io_32_d ? xfer_cnt_t'(2) : xfer_cnt_t'(1));
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mgmt_wr_d <= 1'b0;
			mgmt_rd_d <= 1'b0;
			mgmt_cnt  <= '0;
		end else begin
			mgmt_wr_d <= mgmt_write;
			mgmt_rd_d <= mgmt_read;
			if ((mgmt_wr_d && !mgmt_write) || (mgmt_rd_d && !mgmt_read)) begin
				if (mgmt_address == MG_DATA)
					mgmt_cnt <= mgmt_cnt + xfer_cnt_t'(1);
				else
					mgmt_cnt <= '0;   // Any other register rewinds the buffer.
			end
		end
	end

	assign io_done       = blk_size != '0 && io_cnt >= blk_size;
	assign io_word_odd   = io_cnt[0];
	assign mgmt_word_odd = mgmt_cnt[0];

	// Pause the host once it has caught up with the words supplied so far.
	assign n_data = (mgmt_cnt[`IDE_CNT_W-1:1] <= io_cnt[`IDE_CNT_W-1:1]) && drq && fast_read;

	always_ff @(posedge clk) begin
		if (!rst_n)
			n_data_d <= '0;
		else
			n_data_d <= {n_data_d[0], n_data};
	end

	assign no_data = n_data || |n_data_d;

	// While the host moves a block its count stays inside the block.
	assert property (@(posedge clk) disable iff (reset)
		(drq && blk_size != '0) |-> io_cnt <= blk_size);

	// ##########################################################################
	// Buffer halves. Even words sit in buf_lo and odd words in buf_hi.
	// ##########################################################################

	assign io_hi_data = io_32 ? io_writedata[31:16] : io_writedata[15:0];

	dpram #(.ADDR_W(`IDE_BUF_AW), .DATA_W($bits(tf_word_t))) buf_lo (
		.clk       (clk),
		.address_a (mgmt_cnt[`IDE_BUF_AW:1]),
		.data_a    (mgmt_writedata),
		.wren_a    (mgmt_reg_we[MG_DATA] && !mgmt_cnt[0]),
		.q_a       (buf_readdata[15:0]),
		.address_b (io_cnt[`IDE_BUF_AW:1]),
		.data_b    (io_writedata[15:0]),
		.wren_b    (wr_data && (io_32 || !io_cnt[0])),
		.q_b       (buf_q[15:0])
	);

	dpram #(.ADDR_W(`IDE_BUF_AW), .DATA_W($bits(tf_word_t))) buf_hi (
		.clk       (clk),
		.address_a (mgmt_cnt[`IDE_BUF_AW:1]),
		.data_a    (mgmt_writedata),
		.wren_a    (mgmt_reg_we[MG_DATA] && mgmt_cnt[0]),
		.q_a       (buf_readdata[31:16]),
		.address_b (io_cnt[`IDE_BUF_AW:1]),
		.data_b    (io_hi_data),
		.wren_b    (wr_data && (io_32 || io_cnt[0])),
		.q_b       (buf_q[31:16])
	);

endmodule

`default_nettype wire

/* ide/ide.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ide_params.svh"

module ide
	import ide_regs_pkg::*, ide_xfer_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	output logic                   irq,
	output logic                   drq,
	input  logic                   use_fast,   // Management side supports fast read.
	output logic                   no_data,    // Fast read pause for the host.
	output logic [1:0]             drive_en,

	input  io_addr_t               io_address,
	input  logic                   io_read,
	output logic [`IDE_DATA_W-1:0] io_readdata,
	input  logic                   io_write,
	input  logic [`IDE_DATA_W-1:0] io_writedata,
	input  logic                   io_32,
	output logic                   io_wait,

	output req_code_t              request,

	input  mgmt_addr_t             mgmt_address,
	input  logic                   mgmt_write,
	input  tf_word_t               mgmt_writedata,
	input  logic                   mgmt_read,
	output tf_word_t               mgmt_readdata
);

	logic [`IDE_NREGS-1:0]  io_reg_we;
	logic [`IDE_NREGS-1:0]  mgmt_reg_we;
	logic                   reset;
	status_t                status;
	logic                   hob;
	logic [1:0]             present;
	logic                   fast_read;
	logic                   drv_sel;
	xfer_cnt_t              blk_size;
	logic                   io_done;
	logic [`IDE_DATA_W-1:0] buf_q;
	logic [`IDE_DATA_W-1:0] buf_readdata;
	logic                   io_word_odd;
	logic                   mgmt_word_odd;

	assign drq      = status[ST_DRQ];
	assign drive_en = present;

	// Register decode and command phases.
	ide_sequencer u_sequencer (
		.*,
		.io_writedata (io_writedata[7:0])
	);

	// Task-file registers and both read paths.
	ide_taskfile u_taskfile (
		.*,
		.io_writedata (io_writedata[7:0])
	);

	// Word counters and the sector buffer.
	ide_xfer_buf u_xfer_buf (.*);

endmodule

`default_nettype wire

/* tb/ide_bus_tasks.svh */
`ifndef IDE_BUS_TASKS_SVH
`define IDE_BUS_TASKS_SVH

// ############################################################################
// Host and management bus accesses. Every access ends two idle cycles after
// its strobe falls, so the word counters and the buffer output have settled.
// ############################################################################

task automatic wait_host_ready();
	int n;
	n = 0;
	while (io_wait && n < WAIT_LIMIT) begin
		@(posedge clk);
		#2;
		n++;
	end
	if (io_wait) begin
		errors++;
		$display("%0t: io_wait stayed high, the host bus was never released", $time);
	end
endtask

task automatic host_write(input logic [3:0] addr, input logic [31:0] data, input logic wide);
	wait_host_ready();
	@(posedge clk);
	#2;
	io_address   = addr;
	io_writedata = data;
	io_32        = wide;
	io_write     = 1'b1;
	@(posedge clk);
	#2;
	io_write = 1'b0;
	repeat (2) begin
		@(posedge clk);
		#2;
	end
endtask

task automatic host_read(input logic [3:0] addr, input logic wide, output logic [31:0] data);
	wait_host_ready();
	@(posedge clk);
	#2;
	io_address = addr;
	io_32      = wide;
	io_read    = 1'b1;
	@(posedge clk);
	#2;
	data    = io_readdata;   // Registered one cycle after the strobe.
	io_read = 1'b0;
	repeat (2) begin
		@(posedge clk);
		#2;
	end
endtask

task automatic mgmt_wr(input logic [3:0] addr, input logic [15:0] data);
	@(posedge clk);
	#2;
	mgmt_address   = addr;
	mgmt_writedata = data;
	mgmt_write     = 1'b1;
	@(posedge clk);
	#2;
	mgmt_write = 1'b0;   // Address stays put so the fall is counted here.
	repeat (2) begin
		@(posedge clk);
		#2;
	end
endtask

task automatic mgmt_rd(input logic [3:0] addr, output logic [15:0] data);
	@(posedge clk);
	#2;
	mgmt_address = addr;
	mgmt_read    = 1'b1;
	@(posedge clk);
	#2;
	data      = mgmt_readdata;
	mgmt_read = 1'b0;
	repeat (2) begin
		@(posedge clk);
		#2;
	end
endtask

// ############################################################################
// Waits on DUT outputs and result bookkeeping.
// ############################################################################

task automatic wait_request(input logic [2:0] code);
	int n;
	n = 0;
	while (request !== code && n < WAIT_LIMIT) begin
		@(posedge clk);
		#2;
		n++;
	end
	if (request !== code)
		check_value("request", {29'd0, code}, {29'd0, request});
endtask

task automatic wait_no_data(input logic level);
	int n;
	n = 0;
	while (no_data !== level && n < WAIT_LIMIT) begin
		@(posedge clk);
		#2;
		n++;
	end
	if (no_data !== level)
		check_value("no_data", {31'd0, level}, {31'd0, no_data});
endtask

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (expected !== actual) begin
		errors++;
		$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
	end
endtask

task automatic end_test(input string name);
	tests_run++;
	if (errors == test_mark) begin
		$display("test %0d %s: ok", tests_run, name);
	end else begin
		tests_failed++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - test_mark);
	end
	test_mark = errors;
endtask

`endif

/* tb/tb_ide.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ide;

	localparam int WAIT_LIMIT = 2000;   // Cycles for any single wait.
	localparam logic [2:0] CODE_CMD  = 3'b100;
	localparam logic [2:0] CODE_DATA = 3'b101;
	localparam logic [2:0] CODE_RST  = 3'b110;

	logic        clk;
	logic        rst_n;
	logic [3:0]  io_address;
	logic        io_read;
	logic        io_write;
	logic [31:0] io_writedata;
	logic        io_32;
	logic [31:0] io_readdata;
	logic        io_wait;
	logic [3:0]  mgmt_address;
	logic        mgmt_read;
	logic        mgmt_write;
	logic [15:0] mgmt_writedata;
	logic [15:0] mgmt_readdata;
	logic        irq;
	logic        drq;
	logic        no_data;
	logic [1:0]  drive_en;
	logic [2:0]  request;
	logic        use_fast;

	int          errors;
	int          test_mark;
	int          tests_run;
	int          tests_failed;
	logic        irq_blocked;   // Set while the host has disable_irq written.
	logic [15:0] words [256];
	logic [7:0]  fb [4];
	logic [7:0]  sb [4];
	logic [31:0] d;
	logic [15:0] m;

	`include "ide_bus_tasks.svh"

	ide DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#5ms;
		$display("watchdog: the simulation did not finish in time");
		$display("test failed");
		$finish;
	end

	// ##########################################################################
	// Concurrent checks.
	// ##########################################################################

	assert property (@(posedge clk) disable iff (!rst_n) drq |-> request != CODE_CMD)
	else begin
		errors++;
		$display("%0t: a command request is pending while drq is high", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq) |-> $past(mgmt_write && mgmt_address == 4'd5 && mgmt_writedata[10])
			&& !irq_blocked)
	else begin
		errors++;
		$display("%0t: irq rose without an enabled status post", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(request == CODE_DATA) |-> $past(drq))
	else begin
		errors++;
		$display("%0t: a data block was requested without a block in progress", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(io_read && io_address == 4'd7) |=> !irq)
	else begin
		errors++;
		$display("%0t: a status read did not clear irq", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n) !use_fast |-> !no_data)
	else begin
		errors++;
		$display("%0t: no_data is high outside a fast read", $time);
	end

	// ##########################################################################
	// Stimulus.
	// ##########################################################################

	initial begin
		void'($urandom(32'hd0ae));
		{errors, test_mark, tests_run, tests_failed} = '0;
		irq_blocked    = 1'b0;
		rst_n          = 1'b0;
		io_address     = '0;
		io_read        = 1'b0;
		io_write       = 1'b0;
		io_writedata   = '0;
		io_32          = 1'b0;
		mgmt_address   = '0;
		mgmt_read      = 1'b0;
		mgmt_write     = 1'b0;
		mgmt_writedata = '0;
		use_fast       = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;

		check_value("request", {29'd0, CODE_RST}, {29'd0, request});
		check_value("irq", 32'd0, {31'd0, irq});
		check_value("drq", 32'd0, {31'd0, drq});
		check_value("drive_en", 32'd0, {30'd0, drive_en});
		host_read(4'd7, 1'b0, d);
		check_value("io_readdata", 32'hffff_ffff, d);   // No drive yet.
		mgmt_wr(4'd6, 16'h000b);   // Drive 0 present with HOB support.
		check_value("drive_en", 32'd1, {30'd0, drive_en});
		host_read(4'd7, 1'b0, d);
		check_value("io_readdata", 32'h0000_0080, d);
		end_test("reset and presence");

		for (int i = 0; i < 4; i++) begin
			fb[i] = 8'($urandom);
			sb[i] = 8'($urandom);
			host_write(4'(i + 2), {24'd0, fb[i]}, 1'b0);
			host_write(4'(i + 2), {24'd0, sb[i]}, 1'b0);
		end
		mgmt_rd(4'd1, m);
		check_value("mgmt_readdata", {16'd0, sb[1], sb[0]}, {16'd0, m});
		mgmt_rd(4'd2, m);
		check_value("mgmt_readdata", {16'd0, sb[3], sb[2]}, {16'd0, m});
		mgmt_rd(4'd3, m);
		check_value("mgmt_readdata", {16'd0, fb[1], fb[0]}, {16'd0, m});
		mgmt_rd(4'd4, m);
		check_value("mgmt_readdata", {16'd0, fb[3], fb[2]}, {16'd0, m});
		host_write(4'd14, 32'h80, 1'b0);
		for (int i = 0; i < 4; i++) begin
			host_read(4'(i + 2), 1'b0, d);
			check_value("io_readdata", {24'd0, fb[i]}, d);
		end
		host_write(4'd14, 32'h00, 1'b0);
		host_read(4'd2, 1'b0, d);
		check_value("io_readdata", {24'd0, sb[0]}, d);
		end_test("task file and HOB");

		host_write(4'd7, 32'h20, 1'b0);
		wait_request(CODE_CMD);
		check_value("irq", 32'd0, {31'd0, irq});
		mgmt_wr(4'd5, 16'h4400);   // Ready with irq.
		check_value("irq", 32'd1, {31'd0, irq});
		host_read(4'd7, 1'b0, d);
		check_value("io_readdata", 32'h40, d);
		check_value("irq", 32'd0, {31'd0, irq});
		host_write(4'd14, 32'h02, 1'b0);
		irq_blocked = 1'b1;
		host_write(4'd7, 32'h20, 1'b0);
		mgmt_wr(4'd5, 16'h4400);
		check_value("irq", 32'd0, {31'd0, irq});
		host_write(4'd14, 32'h00, 1'b0);
		irq_blocked = 1'b0;
		mgmt_wr(4'd6, 16'h0300);   // Host waits on each command.
		host_write(4'd7, 32'h20, 1'b0);
		check_value("io_wait", 32'd1, {31'd0, io_wait});
		mgmt_wr(4'd5, 16'h4000);
		check_value("io_wait", 32'd0, {31'd0, io_wait});
		mgmt_wr(4'd6, 16'h0200);
		end_test("command and interrupt");

		host_write(4'd7, 32'h20, 1'b0);
		wait_request(CODE_CMD);
		mgmt_wr(4'd0, 16'h0001);   // One sector, 256 words.
		for (int blk = 0; blk < 2; blk++) begin
			for (int i = 0; i < 256; i++) begin
				words[i] = 16'($urandom);
				mgmt_wr(4'd15, words[i]);
			end
			mgmt_wr(4'd5, blk == 0 ? 16'h0800 : 16'h0a00);   // Second block is the last.
			for (int i = 0; i < 256; i += 2) begin
				if (blk == 0 && i < 128) begin
					host_read(4'd0, 1'b0, d);
					check_value("io_readdata", {16'd0, words[i]}, {16'd0, d[15:0]});
					host_read(4'd0, 1'b0, d);
					check_value("io_readdata", {16'd0, words[i + 1]}, {16'd0, d[15:0]});
				end else begin
					host_read(4'd0, 1'b1, d);
					check_value("io_readdata", {words[i + 1], words[i]}, d);
				end
			end
			if (blk == 0)
				wait_request(CODE_DATA);
		end
		host_read(4'd7, 1'b0, d);
		check_value("io_readdata", 32'h40, d);
		end_test("PIO read block");

		host_write(4'd7, 32'h30, 1'b0);
		wait_request(CODE_CMD);
		mgmt_wr(4'd5, 16'h0800);
		for (int i = 0; i < 256; i += 2) begin
			words[i]     = 16'($urandom);
			words[i + 1] = 16'($urandom);
			if (i < 64) begin
				host_write(4'd0, {16'd0, words[i]}, 1'b0);
				host_write(4'd0, {16'd0, words[i + 1]}, 1'b0);
			end else begin
				host_write(4'd0, {words[i + 1], words[i]}, 1'b1);
			end
		end
		wait_request(CODE_DATA);
		for (int i = 0; i < 256; i++) begin
			mgmt_rd(4'd15, m);
			check_value("mgmt_readdata", {16'd0, words[i]}, {16'd0, m});
		end
		end_test("PIO write block");

		use_fast = 1'b1;
		host_write(4'd7, 32'h20, 1'b0);
		wait_request(CODE_CMD);
		mgmt_wr(4'd5, 16'h6800);   // Fast read with drq and nothing supplied yet.
		wait_no_data(1'b1);
		for (int i = 0; i < 6; i++)
			words[i] = 16'($urandom);
		for (int i = 0; i < 4; i++)
			mgmt_wr(4'd15, words[i]);
		wait_no_data(1'b0);
		for (int i = 0; i < 4; i++) begin
			host_read(4'd0, 1'b0, d);
			check_value("io_readdata", {16'd0, words[i]}, {16'd0, d[15:0]});
			if (i == 1)
				check_value("no_data", 32'd0, {31'd0, no_data});
		end
		wait_no_data(1'b1);   // Host has caught up.
		mgmt_wr(4'd15, words[4]);
		mgmt_wr(4'd15, words[5]);
		wait_no_data(1'b0);
		for (int i = 4; i < 6; i++) begin
			host_read(4'd0, 1'b0, d);
			check_value("io_readdata", {16'd0, words[i]}, {16'd0, d[15:0]});
		end
		end_test("fast read pause");

		host_write(4'd14, 32'h04, 1'b0);
		wait_request(CODE_RST);
		host_read(4'd7, 1'b0, d);
		check_value("io_readdata", 32'h80, d);
		mgmt_rd(4'd1, m);
		check_value("mgmt_readdata", 32'h0101, {16'd0, m});
		host_write(4'd14, 32'h00, 1'b0);
		repeat (4) @(posedge clk);
		#2;
		use_fast = 1'b0;
		end_test("software reset");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
+incdir+tb
common/ide_regs_pkg.sv
common/ide_xfer_pkg.sv
hw/dpram.sv
ide/ide_sequencer.sv
ide/ide_taskfile.sv
ide/ide_xfer_buf.sv
ide/ide.sv
tb/tb_ide.sv

/* run_sim.sh */
#!/bin/sh
# Build the IDE testbench with Verilator, run it, and scan the log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_ide -Mdir obj_dir -f sim.f; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/Vtb_ide > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi

exit 0
